// File: Bender.yml
package:
  name: axi_prefetch

sources:
  - logic/prefetch_pkg.sv
  - logic/prefetch_ctrl.sv
  - logic/ar_issuer.sv
  - logic/r_drain.sv
  - logic/axi_prefetch_top.sv
  - target: simulation
    files:
      - dv/prefetch_checker.sv
      - dv/tb_axi_prefetch.sv

// File: dv/prefetch_checker.sv
`timescale 1ns/1ps
`default_nettype none

module prefetch_checker (
    input  wire                      M_AXI_ACLK,
    input  wire                      M_AXI_ARESETN,
    input  wire                      run_start,
    input  wire prefetch_pkg::addr_t exp_base,
    input  wire                      exp_err,
    input  wire                      arvalid,
    input  wire                      arready,
    input  wire prefetch_pkg::addr_t araddr,
    input  wire [7:0]                arlen,
    input  wire [2:0]                arsize,
    input  wire [1:0]                arburst,
    input  wire [prefetch_pkg::ID_W-1:0] arid,
    input  wire                      rvalid,
    input  wire                      rready,
    input  wire                      rlast,
    input  wire                      prefetch_done,
    input  wire                      prefetch_error,
    output int                       error_count
);

    import prefetch_pkg::*;

    // Start edge to arvalid rise as sampled one edge late
    localparam int FIRST_AR_LAG = 2;

    logic  out_of_reset;
    logic  armed;
    logic  first_ar_seen;
    logic  stall_prev;
    logic  done_prev;
    logic  err_prev;
    addr_t addr_prev;
    addr_t want;
    int    ar_count;
    int    last_count;
    int    since_start;

    task automatic report_mismatch(input string msg);
        error_count++;
        $display("CHECK FAILED at %0t: %s", $time, msg);
    endtask

    always @(posedge M_AXI_ACLK)
    begin
        if (!M_AXI_ARESETN)
        begin
            out_of_reset = 1'b0;
            armed = 1'b0;
            stall_prev = 1'b0;
            done_prev = 1'b0;
            err_prev = 1'b0;
        end
        else
        begin
            // First edge after reset
            if (!out_of_reset && (arvalid || rready || prefetch_done || prefetch_error))
            begin
                report_mismatch("outputs not idle after reset");
            end
            out_of_reset = 1'b1;

            ////////////////////////////////////////
            // Run bookkeeping
            ////////////////////////////////////////
            if (run_start)
            begin
                armed = 1'b1;
                first_ar_seen = 1'b0;
                ar_count = 0;
                last_count = 0;
                since_start = 0;
            end
            else
            begin
                since_start++;
            end
            if (armed && !first_ar_seen && arvalid)
            begin
                first_ar_seen = 1'b1;
                if (since_start != FIRST_AR_LAG + 1)
                begin
                    report_mismatch($sformatf("first arvalid after %0d cycles", since_start - 1));
                end
            end

            // Stalled address must hold
            if (stall_prev && !(arvalid && araddr == addr_prev))
            begin
                report_mismatch("araddr or arvalid changed while arready was low");
            end

            ////////////////////////////////////////
            // AR handshake
            ////////////////////////////////////////
            if (arvalid && arready)
            begin
                if (!armed || ar_count >= PREFETCH_BURSTS)
                begin
                    report_mismatch($sformatf("unexpected AR handshake at %h", araddr));
                end
                else
                begin
                    want = exp_base + addr_t'(ar_count * BURST_BYTES);
                    if (araddr !== want)
                    begin
                        report_mismatch($sformatf("araddr %h, expected %h", araddr, want));
                    end
                    if (arlen !== 8'(BURST_LEN - 1) || arsize !== 3'(AXI_SIZE) ||
                        arburst !== 2'b01)
                    begin
                        report_mismatch($sformatf("burst shape len %0d size %0d burst %0d",
                                                  arlen, arsize, arburst));
                    end
                    // Single ID master
                    if (arid !== '0)
                    begin
                        report_mismatch($sformatf("arid %h, expected 0", arid));
                    end
                end
                ar_count++;
            end

            if (rvalid && rready && rlast)
            begin
                last_count++;
            end

            ////////////////////////////////////////
            // Completion and error flag
            ////////////////////////////////////////
            if (prefetch_done && done_prev)
            begin
                report_mismatch("prefetch_done longer than one cycle");
            end
            else if (prefetch_done)
            begin
                if (!armed)
                begin
                    report_mismatch("prefetch_done outside a run");
                end
                if (ar_count != PREFETCH_BURSTS || last_count != PREFETCH_BURSTS)
                begin
                    report_mismatch($sformatf("done after %0d addresses, %0d bursts back",
                                              ar_count, last_count));
                end
                if (prefetch_error !== exp_err)
                begin
                    report_mismatch($sformatf("prefetch_error %b, expected %b",
                                              prefetch_error, exp_err));
                end
                armed = 1'b0;
            end
            // Sticky until reset
            if (err_prev && !prefetch_error)
            begin
                report_mismatch("prefetch_error cleared without reset");
            end

            stall_prev = arvalid && !arready;
            addr_prev = araddr;
            done_prev = prefetch_done;
            err_prev = prefetch_error;
        end
    end

endmodule

`default_nettype wire

// File: dv/tb_axi_prefetch.sv
`timescale 1ns/1ps
`default_nettype none

module tb_axi_prefetch;

    import prefetch_pkg::*;

    localparam int    RUN_TIMEOUT = 5000;
    localparam resp_t RESP_SLVERR = 2'b10;
    // Index no run ever issues
    localparam burst_idx_t NO_ERR = burst_idx_t'(PREFETCH_BURSTS);
    // Offset of the load made while a run is going
    localparam addr_t MID_RUN_STEP = 32'h0001_0000;

    // One run per row
    typedef struct packed {
        addr_t      base;
        logic [1:0] density;
        burst_idx_t err_burst;
        logic       reload;
    } run_row_t;

    localparam int NUM_RUNS = 5;
    localparam run_row_t RUNS [NUM_RUNS] = '{
        '{32'h1000_0000, 2'd0, NO_ERR,          1'b1},
        '{32'h2000_0400, 2'd2, NO_ERR,          1'b1},
        // No reload here
        // Picks up the load made during the run before
        '{32'h0000_0000, 2'd1, NO_ERR,          1'b0},
        '{32'h3000_0000, 2'd3, burst_idx_t'(5), 1'b1},
        '{32'h0000_8000, 2'd1, NO_ERR,          1'b1}
    };

    logic M_AXI_ACLK = 1'b0;
    logic M_AXI_ARESETN;
    logic init_txn;
    logic base_addr_set;
    addr_t base_addr;
    wire  prefetch_done;
    wire  prefetch_error;
    wire [ID_W-1:0] arid;
    addr_t araddr;
    wire [7:0] arlen;
    wire [2:0] arsize;
    wire [1:0] arburst;
    wire  arvalid;
    logic arready = 1'b0;
    data_t rdata = '0;
    resp_t rresp = RESP_OKAY;
    logic rlast = 1'b0;
    logic rvalid = 1'b0;
    wire  rready;

    // Expectations handed to the checker
    logic run_start;
    addr_t exp_base;
    logic exp_err;
    logic [1:0] cur_density;
    burst_idx_t cur_err;
    int   error_count;

    // Slave model state
    logic [31:0] lfsr_state;
    bit   err_q[$];
    int   ar_idx;
    int   beat_idx;

    // Testbench copy of the base holding register
    addr_t hold_base;
    logic err_sticky;
    int   timeouts;
    logic aborted;

    always #2 M_AXI_ACLK = ~M_AXI_ACLK;

    axi_prefetch_top u_axi_prefetch_top (
        .M_AXI_ACLK     (M_AXI_ACLK),
        .M_AXI_ARESETN  (M_AXI_ARESETN),
        .init_txn       (init_txn),
        .base_addr_set  (base_addr_set),
        .base_addr      (base_addr),
        .prefetch_done  (prefetch_done),
        .prefetch_error (prefetch_error),
        .M_AXI_ARID     (arid),
        .M_AXI_ARADDR   (araddr),
        .M_AXI_ARLEN    (arlen),
        .M_AXI_ARSIZE   (arsize),
        .M_AXI_ARBURST  (arburst),
        .M_AXI_ARVALID  (arvalid),
        .M_AXI_ARREADY  (arready),
        .M_AXI_RDATA    (rdata),
        .M_AXI_RRESP    (rresp),
        .M_AXI_RLAST    (rlast),
        .M_AXI_RVALID   (rvalid),
        .M_AXI_RREADY   (rready)
    );

    prefetch_checker u_checker (
        .M_AXI_ACLK     (M_AXI_ACLK),
        .M_AXI_ARESETN  (M_AXI_ARESETN),
        .run_start      (run_start),
        .exp_base       (exp_base),
        .exp_err        (exp_err),
        .arvalid        (arvalid),
        .arready        (arready),
        .araddr         (araddr),
        .arlen          (arlen),
        .arsize         (arsize),
        .arburst        (arburst),
        .arid           (arid),
        .rvalid         (rvalid),
        .rready         (rready),
        .rlast          (rlast),
        .prefetch_done  (prefetch_done),
        .prefetch_error (prefetch_error),
        .error_count    (error_count)
    );

    ////////////////////////////////////////
    // LFSR and slave model
    ////////////////////////////////////////

    // Taps 32, 22, 2 and 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // Two bits per draw
    // Stall when below the density
    task automatic roll_stall(input logic [1:0] density, output logic stall);
        logic [1:0] r;
        lfsr_state = lfsr_next(lfsr_state);
        r[0] = lfsr_state[0];
        lfsr_state = lfsr_next(lfsr_state);
        r[1] = lfsr_state[0];
        stall = (r < density);
    endtask

    always @(posedge M_AXI_ACLK)
    begin
        logic stall;
        if (!M_AXI_ARESETN)
        begin
            lfsr_state = 32'h960a;
            err_q.delete();
            ar_idx = 0;
            beat_idx = 0;
            arready <= 1'b0;
            rvalid <= 1'b0;
            rlast <= 1'b0;
        end
        else
        begin
            if (run_start)
            begin
                ar_idx = 0;
            end
            // Queue the burst tagged if it should fail
            if (arvalid && arready)
            begin
                err_q.push_back(burst_idx_t'(ar_idx) == cur_err);
                ar_idx++;
            end
            roll_stall(cur_density, stall);
            arready <= !stall;
            if (rvalid && rready)
            begin
                if (rlast)
                begin
                    err_q.delete(0);
                    beat_idx = 0;
                end
                else
                begin
                    beat_idx++;
                end
            end
            // Next beat once the current one is gone
            if (!rvalid || rready)
            begin
                roll_stall(cur_density, stall);
                if (err_q.size() > 0 && !stall)
                begin
                    rvalid <= 1'b1;
                    rlast <= (beat_idx == BURST_LEN - 1);
                    rresp <= err_q[0] ? RESP_SLVERR : RESP_OKAY;
                    rdata <= lfsr_state;
                end
                else
                begin
                    rvalid <= 1'b0;
                end
            end
        end
    end

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    task automatic load_base(input addr_t value);
        @(posedge M_AXI_ACLK);
        base_addr <= value;
        base_addr_set <= 1'b1;
        @(posedge M_AXI_ACLK);
        base_addr_set <= 1'b0;
        hold_base = value;
    endtask

    task automatic run_row(input run_row_t row, input int idx);
        int   waited;
        logic seen;
        if (row.reload)
        begin
            load_base(row.base);
        end
        err_sticky = err_sticky || (row.err_burst != NO_ERR);
        @(posedge M_AXI_ACLK);
        init_txn <= 1'b1;
        run_start <= 1'b1;
        exp_base <= hold_base;
        exp_err <= err_sticky;
        cur_density <= row.density;
        cur_err <= row.err_burst;
        @(posedge M_AXI_ACLK);
        init_txn <= 1'b0;
        run_start <= 1'b0;
        // Load during the run
        // Only the next run may see it
        repeat (3) @(posedge M_AXI_ACLK);
        load_base(hold_base + MID_RUN_STEP);
        waited = 0;
        seen = 1'b0;
        while (!seen && waited < RUN_TIMEOUT)
        begin
            @(posedge M_AXI_ACLK);
            waited++;
            seen = prefetch_done;
        end
        if (!seen)
        begin
            timeouts++;
            aborted = 1'b1;
            $display("Timeout: run %0d never raised prefetch_done", idx);
        end
        @(posedge M_AXI_ACLK);
    endtask

    initial
    begin
        M_AXI_ARESETN = 1'b0;
        init_txn = 1'b0;
        base_addr_set = 1'b0;
        base_addr = '0;
        run_start = 1'b0;
        exp_base = '0;
        exp_err = 1'b0;
        cur_density = 2'd0;
        cur_err = NO_ERR;
        hold_base = '0;
        err_sticky = 1'b0;
        timeouts = 0;
        aborted = 1'b0;
        repeat (3) @(posedge M_AXI_ACLK);
        M_AXI_ARESETN <= 1'b1;
        // Base load alone must not start anything
        load_base(32'h0bad_0000);
        repeat (20) @(posedge M_AXI_ACLK);
        for (int i = 0; i < NUM_RUNS; i++)
        begin
            if (!aborted)
            begin
                run_row(RUNS[i], i);
            end
        end
        // Quiet tail to catch stray addresses
        repeat (20) @(posedge M_AXI_ACLK);
        $display("Mismatches: %0d, timeouts: %0d", error_count, timeouts);
        if (error_count == 0 && timeouts == 0)
        begin
            $display("Regression passed");
        end
        else
        begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
logic/prefetch_pkg.sv
logic/prefetch_ctrl.sv
logic/ar_issuer.sv
logic/r_drain.sv
logic/axi_prefetch_top.sv
dv/prefetch_checker.sv
dv/tb_axi_prefetch.sv

// File: logic/ar_issuer.sv
`timescale 1ns/1ps
`default_nettype none

module ar_issuer (
    input  wire                  M_AXI_ACLK,
    input  wire                  M_AXI_ARESETN,
    input  wire                  burst_req,
    input  wire prefetch_pkg::addr_t burst_addr,
    input  wire                  arready,
    output logic                 burst_ack,
    output logic                 arvalid,
    output prefetch_pkg::addr_t  araddr,
    output logic [7:0]           arlen,
    output logic [2:0]           arsize,
    output logic [1:0]           arburst,
    output logic [prefetch_pkg::ID_W-1:0] arid
);

    import prefetch_pkg::*;

    logic launch;
    logic ar_done;

    // New request with the previous ack already gone
    assign launch = burst_req && !burst_ack && !arvalid;
    assign ar_done = arvalid && arready;

    ////////////////////////////////////////
    // AR channel
    ////////////////////////////////////////

    // VALID held until the slave takes it
    always_ff @(posedge M_AXI_ACLK)
    begin
        if (!M_AXI_ARESETN)
        begin
            arvalid <= 1'b0;
        end
        else if (ar_done)
        begin
            arvalid <= 1'b0;
        end
        else if (launch)
        begin
            arvalid <= 1'b1;
        end
    end

    // Address captured at launch only
    always_ff @(posedge M_AXI_ACLK)
    begin
        if (launch)
        begin
            araddr <= burst_addr;
        end
    end

    // Fixed burst shape
    assign arlen   = 8'(BURST_LEN - 1);
    assign arsize  = 3'(AXI_SIZE);
    assign arburst = AXI_BURST_INCR;
    // Single thread
    assign arid    = '0;

    ////////////////////////////////////////
    // Ack half of the handshake
    ////////////////////////////////////////

    always_ff @(posedge M_AXI_ACLK)
    begin
        if (!M_AXI_ARESETN)
        begin
            burst_ack <= 1'b0;
        end
        // Raised the cycle after the AR handshake
        else if (ar_done)
        begin
            burst_ack <= 1'b1;
        end
        // Dropped once the controller lets go
        else if (!burst_req)
        begin
            burst_ack <= 1'b0;
        end
    end

    // AXI rule on stalled address
    ar_hold: assert property (
        @(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
        arvalid && !arready |=> arvalid && $stable(araddr)
    );

endmodule

`default_nettype wire

// File: logic/axi_prefetch_top.sv
`timescale 1ns/1ps
`default_nettype none

module axi_prefetch_top (
    // Clock and reset
    input  wire                            M_AXI_ACLK,
    input  wire                            M_AXI_ARESETN,

    // Run control
    input  wire                            init_txn,
    input  wire                            base_addr_set,
    input  wire prefetch_pkg::addr_t       base_addr,
    output wire                            prefetch_done,
    output wire                            prefetch_error,

    // Read address channel
    output wire [prefetch_pkg::ID_W-1:0]   M_AXI_ARID,
    output wire prefetch_pkg::addr_t       M_AXI_ARADDR,
    output wire [7:0]                      M_AXI_ARLEN,
    output wire [2:0]                      M_AXI_ARSIZE,
    output wire [1:0]                      M_AXI_ARBURST,
    output wire                            M_AXI_ARVALID,
    input  wire                            M_AXI_ARREADY,

    // Read data channel
    input  wire prefetch_pkg::data_t       M_AXI_RDATA,
    input  wire prefetch_pkg::resp_t       M_AXI_RRESP,
    input  wire                            M_AXI_RLAST,
    input  wire                            M_AXI_RVALID,
    output wire                            M_AXI_RREADY
);

    import prefetch_pkg::*;

    ////////////////////////////////////////
    // Internal links
    ////////////////////////////////////////

    // Controller to issuer request pair
    logic  burst_req;
    logic  burst_ack;
    addr_t burst_addr;
    // Drain back to controller
    logic  burst_retired;
    logic  run_active;

    // Run FSM and base latch
    prefetch_ctrl u_ctrl (
        .M_AXI_ACLK    (M_AXI_ACLK),
        .M_AXI_ARESETN (M_AXI_ARESETN),
        .init_txn      (init_txn),
        .base_addr_set (base_addr_set),
        .base_addr     (base_addr),
        .burst_ack     (burst_ack),
        .burst_retired (burst_retired),
        .burst_req     (burst_req),
        .burst_addr    (burst_addr),
        .run_active    (run_active),
        .prefetch_done (prefetch_done)
    );

    // One AR burst per request
    ar_issuer u_issuer (
        .M_AXI_ACLK    (M_AXI_ACLK),
        .M_AXI_ARESETN (M_AXI_ARESETN),
        .burst_req     (burst_req),
        .burst_addr    (burst_addr),
        .arready       (M_AXI_ARREADY),
        .burst_ack     (burst_ack),
        .arvalid       (M_AXI_ARVALID),
        .araddr        (M_AXI_ARADDR),
        .arlen         (M_AXI_ARLEN),
        .arsize        (M_AXI_ARSIZE),
        .arburst       (M_AXI_ARBURST),
        .arid          (M_AXI_ARID)
    );

    // Sink for returned data
    r_drain u_drain (
        .M_AXI_ACLK     (M_AXI_ACLK),
        .M_AXI_ARESETN  (M_AXI_ARESETN),
        .run_active     (run_active),
        .rvalid         (M_AXI_RVALID),
        .rlast          (M_AXI_RLAST),
        .rresp          (M_AXI_RRESP),
        .rdata          (M_AXI_RDATA),
        .rready         (M_AXI_RREADY),
        .burst_retired  (burst_retired),
        .prefetch_error (prefetch_error)
    );

endmodule

`default_nettype wire

// File: logic/prefetch_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module prefetch_ctrl (
    input  wire                 M_AXI_ACLK,
    input  wire                 M_AXI_ARESETN,
    input  wire                 init_txn,
    input  wire                 base_addr_set,
    input  wire prefetch_pkg::addr_t base_addr,
    input  wire                 burst_ack,
    input  wire                 burst_retired,
    output logic                burst_req,
    output prefetch_pkg::addr_t burst_addr,
    output logic                run_active,
    output logic                prefetch_done
);

    import prefetch_pkg::*;

    ctrl_state_t state;
    // Software-loaded base, may change at any time
    addr_t       base_hold;
    // Base frozen for the current run
    addr_t       base_run;
    burst_idx_t  issued;
    burst_idx_t  retired;
    logic        start;
    logic        all_issued;
    logic        last_retire;

    // Start only honored from IDLE
    assign start = (state == IDLE) && init_txn;
    assign all_issued = (issued == burst_idx_t'(PREFETCH_BURSTS));
    // Final rlast of the run
    assign last_retire = burst_retired && (retired == burst_idx_t'(PREFETCH_BURSTS - 1));

    ////////////////////////////////////////
    // Base address
    ////////////////////////////////////////

    always_ff @(posedge M_AXI_ACLK)
    begin
        if (base_addr_set)
        begin
            base_hold <= base_addr;
        end
    end

    // Snapshot at run start, later loads wait for the next run
    always_ff @(posedge M_AXI_ACLK)
    begin
        if (start)
        begin
            base_run <= base_hold;
        end
    end

    // Consecutive bursts from the frozen base
    assign burst_addr = base_run + addr_t'(issued) * addr_t'(BURST_BYTES);

    ////////////////////////////////////////
    // Run FSM
    ////////////////////////////////////////

    always_ff @(posedge M_AXI_ACLK)
    begin
        if (!M_AXI_ARESETN)
        begin
            state <= IDLE;
        end
        else
        begin
            case (state)
                IDLE:
                begin
                    if (init_txn)
                    begin
                        state <= PREFETCH;
                    end
                end
                // Stay until every burst has come back
                PREFETCH:
                begin
                    if (last_retire)
                    begin
                        state <= FINISH;
                    end
                end
                // One cycle only, drives the done pulse
                FINISH:
                begin
                    state <= IDLE;
                end
                default:
                begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Issue and retire counters
    always_ff @(posedge M_AXI_ACLK)
    begin
        if (!M_AXI_ARESETN)
        begin
            issued  <= '0;
            retired <= '0;
        end
        else if (start)
        begin
            issued  <= '0;
            retired <= '0;
        end
        else if (state == PREFETCH)
        begin
            // Ack seen means the address went out
            if (burst_req && burst_ack)
            begin
                issued <= issued + 1'b1;
            end
            if (burst_retired)
            begin
                retired <= retired + 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // Four-phase request to the issuer
    ////////////////////////////////////////

    always_ff @(posedge M_AXI_ACLK)
    begin
        if (!M_AXI_ARESETN)
        begin
            burst_req <= 1'b0;
        end
        else if (state != PREFETCH)
        begin
            burst_req <= 1'b0;
        end
        // Phase 3, release on ack
        else if (burst_req && burst_ack)
        begin
            burst_req <= 1'b0;
        end
        // Next request waits for ack low
        else if (!burst_req && !burst_ack && !all_issued)
        begin
            burst_req <= 1'b1;
        end
    end

    // R channel open for the whole run
    assign run_active = (state == PREFETCH);
    assign prefetch_done = (state == FINISH);

    // Address held for the whole request phase
    req_addr_stable: assert property (
        @(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
        burst_req |=> !burst_req || $stable(burst_addr)
    );

    // Drain never retires more bursts than were issued
    retire_after_issue: assert property (
        @(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
        burst_retired |-> (retired < issued)
    );

endmodule

`default_nettype wire

// File: logic/prefetch_pkg.sv
`default_nettype none

package prefetch_pkg;

    ////////////////////////////////////////
    // Bus geometry
    ////////////////////////////////////////

    // Byte address and data widths of the master port
    localparam int unsigned ADDR_W = 32;
    localparam int unsigned DATA_W = 32;
    // Single thread, so one ID bit is plenty
    localparam int unsigned ID_W = 1;

    // Burst shape
    localparam int unsigned BURST_LEN = 16;
    localparam int unsigned BURST_BYTES = BURST_LEN * (DATA_W / 8);
    // Bursts per run, kept small for short runs
    localparam int unsigned PREFETCH_BURSTS = 8;

    // AxSIZE for full-width beats (4 bytes)
    localparam int unsigned AXI_SIZE = $clog2(DATA_W / 8);
    // Incrementing burst
    localparam logic [1:0] AXI_BURST_INCR = 2'b01;

    ////////////////////////////////////////
    // Types
    ////////////////////////////////////////

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    // Holds 0 up to PREFETCH_BURSTS inclusive
    typedef logic [$clog2(PREFETCH_BURSTS + 1)-1:0] burst_idx_t;
    // Holds 0 up to BURST_LEN inclusive
    typedef logic [$clog2(BURST_LEN + 1)-1:0] beat_cnt_t;
    typedef logic [1:0] resp_t;

    // Normal access success
    localparam resp_t RESP_OKAY = 2'b00;

    // Run controller states
    typedef enum logic [1:0] {
        IDLE,
        PREFETCH,
        FINISH
    } ctrl_state_t;

endpackage

`default_nettype wire

// File: logic/r_drain.sv
`timescale 1ns/1ps
`default_nettype none

module r_drain (
    input  wire                  M_AXI_ACLK,
    input  wire                  M_AXI_ARESETN,
    input  wire                  run_active,
    input  wire                  rvalid,
    input  wire                  rlast,
    input  wire prefetch_pkg::resp_t rresp,
    input  wire prefetch_pkg::data_t rdata,
    output logic                 rready,
    output logic                 burst_retired,
    output logic                 prefetch_error
);

    import prefetch_pkg::*;

    beat_cnt_t beat_cnt;
    logic      beat;

    // No back-pressure while a run is on
    assign rready = run_active;
    assign beat = rvalid && rready;

    // rdata deliberately dropped
    // the read itself warms the memory system

    ////////////////////////////////////////
    // Beat and burst tracking
    ////////////////////////////////////////

    always_ff @(posedge M_AXI_ACLK)
    begin
        if (!M_AXI_ARESETN)
        begin
            beat_cnt <= '0;
        end
        else if (beat)
        begin
            // Restart at each burst boundary
            if (rlast)
            begin
                beat_cnt <= '0;
            end
            else
            begin
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

    // Same cycle as the accepted last beat
    assign burst_retired = beat && rlast;

    ////////////////////////////////////////
    // Error flag
    ////////////////////////////////////////

    // Sticky until reset, survives later runs
    always_ff @(posedge M_AXI_ACLK)
    begin
        if (!M_AXI_ARESETN)
        begin
            prefetch_error <= 1'b0;
        end
        else if (beat && (rresp != RESP_OKAY))
        begin
            prefetch_error <= 1'b1;
        end
    end

    // Slave must close each burst on exactly beat BURST_LEN
    rlast_position: assert property (
        @(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
        beat |-> (rlast == (beat_cnt == beat_cnt_t'(BURST_LEN - 1)))
    );

endmodule

`default_nettype wire
